/* logic/router_pkg.sv */
//////////////////////////////
// router widths, port ids, descriptor and table structs
//////////////////////////////

`default_nettype none

package router_pkg;

    //////////////////////////////
    // plain vector types
    typedef logic [7:0]  rtl_port_t;    // rtl port index
    typedef logic [7:0]  p4_port_t;     // program port id
    typedef logic [15:0] dst_addr_t;    // destination address
    typedef logic [7:0]  pkt_tag_t;     // opaque tag, carried through
    typedef logic [2:0]  tbl_idx_t;     // forwarding table index
    typedef logic [15:0] drop_cnt_t;    // drop counter

    //////////////////////////////
    // rtl port order
    localparam rtl_port_t CPU_RTL_ID   = 8'd0;
    localparam rtl_port_t OISL0_RTL_ID = 8'd1;
    localparam rtl_port_t OISL1_RTL_ID = 8'd2;
    localparam rtl_port_t ECP0_RTL_ID  = 8'd3;
    localparam rtl_port_t ECP1_RTL_ID  = 8'd4;
    localparam rtl_port_t HDR0_RTL_ID  = 8'd5;
    localparam rtl_port_t HDR1_RTL_ID  = 8'd6;
    localparam rtl_port_t ECG0_RTL_ID  = 8'd7;
    localparam rtl_port_t ECG1_RTL_ID  = 8'd8;
    localparam rtl_port_t ECG2_RTL_ID  = 8'd9;
    localparam rtl_port_t ECG3_RTL_ID  = 8'd10;

    // ids as seen by the forwarding program
    localparam p4_port_t CPU_P4_ID   = 8'd0;
    localparam p4_port_t OISL0_P4_ID = 8'd20;
    localparam p4_port_t OISL1_P4_ID = 8'd21;
    localparam p4_port_t ECP0_P4_ID  = 8'd40;
    localparam p4_port_t ECP1_P4_ID  = 8'd41;
    localparam p4_port_t HDR0_P4_ID  = 8'd60;
    localparam p4_port_t HDR1_P4_ID  = 8'd61;
    localparam p4_port_t ECG0_P4_ID  = 8'd80;
    localparam p4_port_t ECG1_P4_ID  = 8'd81;
    localparam p4_port_t ECG2_P4_ID  = 8'd82;
    localparam p4_port_t ECG3_P4_ID  = 8'd83;

    localparam logic [7:0] INVALID_PORT = 8'hFF;    // unmapped, either direction

    //////////////////////////////
    // depths and counter widths
    localparam int TABLE_DEPTH = 8;
    localparam int IN_CREDITS  = 4;     // ingress fifo depth = upstream credits
    localparam int OUT_CREDITS = 4;     // egress credits after reset
    localparam int IN_PTR_W    = $clog2(IN_CREDITS);
    localparam int IN_CNT_W    = $clog2(IN_CREDITS + 1);
    localparam int OUT_CNT_W   = $clog2(OUT_CREDITS + 1);

    typedef logic [IN_PTR_W-1:0]  in_ptr_t;
    typedef logic [IN_CNT_W-1:0]  in_cnt_t;
    typedef logic [OUT_CNT_W-1:0] credit_cnt_t;

    //////////////////////////////
    // structs
    typedef struct packed {
        rtl_port_t port;        // ingress idx in, egress idx out
        dst_addr_t dst_addr;
        pkt_tag_t  tag;
    } pkt_desc_t;               // 32 bits

    typedef struct packed {
        p4_port_t  ing_p4;
        p4_port_t  egr_p4;      // filled by the table stage
        dst_addr_t dst_addr;
        pkt_tag_t  tag;
    } route_meta_t;             // 40 bits

    typedef struct packed {
        logic      valid;
        dst_addr_t dst_addr;    // exact match key
        p4_port_t  egr_p4;      // action result
    } tbl_entry_t;              // 25 bits

endpackage

`default_nettype wire

/* logic/port_id_map.sv */
//////////////////////////////
// rtl index <-> program port id translation
//////////////////////////////

`timescale 1ns/1ns
`default_nettype none

module port_id_map (
    input  var router_pkg::rtl_port_t ing_rtl,
    output var router_pkg::p4_port_t  ing_p4,
    output var logic                  ing_bad,
    input  var router_pkg::p4_port_t  egr_p4,
    output var router_pkg::rtl_port_t egr_rtl,
    output var logic                  egr_bad
);

    import router_pkg::*;

    //////////////////////////////
    // ingress: rtl -> program
    always_comb begin
        case (ing_rtl)
            CPU_RTL_ID   : ing_p4 = CPU_P4_ID;
            OISL0_RTL_ID : ing_p4 = OISL0_P4_ID;
            OISL1_RTL_ID : ing_p4 = OISL1_P4_ID;
            ECP0_RTL_ID  : ing_p4 = ECP0_P4_ID;
            ECP1_RTL_ID  : ing_p4 = ECP1_P4_ID;
            HDR0_RTL_ID  : ing_p4 = HDR0_P4_ID;
            HDR1_RTL_ID  : ing_p4 = HDR1_P4_ID;
            ECG0_RTL_ID  : ing_p4 = ECG0_P4_ID;
            ECG1_RTL_ID  : ing_p4 = ECG1_P4_ID;
            ECG2_RTL_ID  : ing_p4 = ECG2_P4_ID;
            ECG3_RTL_ID  : ing_p4 = ECG3_P4_ID;
            default      : ing_p4 = INVALID_PORT;   // idx 11 and up
        endcase
    end

    assign ing_bad = (ing_p4 == INVALID_PORT);      // no real id is ff

    //////////////////////////////
    // egress: program -> rtl
    always_comb begin
        case (egr_p4)
            CPU_P4_ID   : egr_rtl = CPU_RTL_ID;
            OISL0_P4_ID : egr_rtl = OISL0_RTL_ID;
            OISL1_P4_ID : egr_rtl = OISL1_RTL_ID;
            ECP0_P4_ID  : egr_rtl = ECP0_RTL_ID;
            ECP1_P4_ID  : egr_rtl = ECP1_RTL_ID;
            HDR0_P4_ID  : egr_rtl = HDR0_RTL_ID;
            HDR1_P4_ID  : egr_rtl = HDR1_RTL_ID;
            ECG0_P4_ID  : egr_rtl = ECG0_RTL_ID;
            ECG1_P4_ID  : egr_rtl = ECG1_RTL_ID;
            ECG2_P4_ID  : egr_rtl = ECG2_RTL_ID;
            ECG3_P4_ID  : egr_rtl = ECG3_RTL_ID;
            default     : egr_rtl = INVALID_PORT;   // gaps in the id space
        endcase
    end

    assign egr_bad = (egr_rtl == INVALID_PORT);

endmodule

`default_nettype wire

/* logic/ingress_buffer.sv */
//////////////////////////////
// ingress descriptor fifo, one credit back per pop
//////////////////////////////

`timescale 1ns/1ns
`default_nettype none

module ingress_buffer (
    input  var logic                  clk,
    input  var logic                  rst,
    input  var logic                  in_valid,
    input  var router_pkg::pkt_desc_t in_desc,
    input  var logic                  pop,
    output var logic                  head_valid,
    output var router_pkg::pkt_desc_t head_desc,
    output var logic                  in_credit
);

    import router_pkg::*;

    pkt_desc_t mem [IN_CREDITS];    // descriptor storage
    in_ptr_t   wr_ptr;
    in_ptr_t   rd_ptr;
    in_cnt_t   count;               // entries held
    logic      do_pop;

    assign do_pop = pop && head_valid;  // never pop an empty fifo

    //////////////////////////////
    // pointers, count, credit pulse
    always_ff @(posedge clk) begin
        if (rst) begin
            wr_ptr    <= '0;
            rd_ptr    <= '0;
            count     <= '0;
            in_credit <= 1'b0;
        end else begin
            if (in_valid) wr_ptr <= wr_ptr + 1'b1;     // wraps at depth
            if (do_pop)   rd_ptr <= rd_ptr + 1'b1;
            case ({in_valid, do_pop})
                2'b10:   count <= count + 1'b1;
                2'b01:   count <= count - 1'b1;
                default: count <= count;               // both or neither
            endcase
            in_credit <= do_pop;                       // cycle after the pop
        end
    end

    // upstream holds a credit for every write, so no full check
    always_ff @(posedge clk) begin
        if (in_valid) mem[wr_ptr] <= in_desc;
    end

    assign head_valid = (count != '0);
    assign head_desc  = mem[rd_ptr];    // visible the cycle after the write

endmodule

`default_nettype wire

/* logic/forward_table.sv */
//////////////////////////////
// exact-match forwarding table, registered lookup
//////////////////////////////

`timescale 1ns/1ns
`default_nettype none

module forward_table (
    input  var logic                    clk,
    input  var logic                    rst,
    input  var logic                    tbl_wr_en,
    input  var router_pkg::tbl_idx_t    tbl_wr_idx,
    input  var router_pkg::tbl_entry_t  tbl_wr_entry,
    input  var logic                    req_valid,
    input  var router_pkg::route_meta_t req_meta,
    input  var logic                    stall,
    output var logic                    lkp_valid,
    output var logic                    lkp_hit,
    output var router_pkg::route_meta_t lkp_meta
);

    import router_pkg::*;

    logic [TABLE_DEPTH-1:0] ent_valid;              // per entry, cleared by reset
    dst_addr_t              ent_addr [TABLE_DEPTH]; // match keys
    p4_port_t               ent_port [TABLE_DEPTH]; // egress ids
    logic                   hit;
    p4_port_t               hit_port;

    //////////////////////////////
    // table writes
    always_ff @(posedge clk) begin
        if (rst) begin
            ent_valid <= '0;
        end else if (tbl_wr_en) begin
            ent_valid[tbl_wr_idx] <= tbl_wr_entry.valid;
        end
    end

    always_ff @(posedge clk) begin
        if (tbl_wr_en) begin
            ent_addr[tbl_wr_idx] <= tbl_wr_entry.dst_addr;
            ent_port[tbl_wr_idx] <= tbl_wr_entry.egr_p4;
        end
    end

    //////////////////////////////
    // parallel compare
    // scanning downward lets the lowest matching index win
    always_comb begin
        hit      = 1'b0;
        hit_port = INVALID_PORT;        // miss -> unmapped id
        for (int i = TABLE_DEPTH - 1; i >= 0; i--) begin
            if (ent_valid[i] && (ent_addr[i] == req_meta.dst_addr)) begin
                hit      = 1'b1;
                hit_port = ent_port[i];
            end
        end
    end

    //////////////////////////////
    // lookup register, held on stall
    always_ff @(posedge clk) begin
        if (rst) begin
            lkp_valid <= 1'b0;
        end else if (!stall) begin
            lkp_valid <= req_valid;
        end
    end

    always_ff @(posedge clk) begin
        if (!stall) begin
            lkp_hit         <= hit;
            lkp_meta        <= req_meta;
            lkp_meta.egr_p4 <= hit_port;   // action fills egress id
        end
    end

endmodule

`default_nettype wire

/* logic/egress_credit.sv */
//////////////////////////////
// egress output register and credit counter
//////////////////////////////

`timescale 1ns/1ns
`default_nettype none

module egress_credit (
    input  var logic                  clk,
    input  var logic                  rst,
    input  var logic                  send_valid,
    input  var router_pkg::pkt_desc_t send_desc,
    input  var logic                  out_credit,
    output var logic                  stall,
    output var logic                  out_valid,
    output var router_pkg::pkt_desc_t out_desc
);

    import router_pkg::*;

    credit_cnt_t credits;       // credits held toward the sink
    logic        send_ok;       // descriptor accepted this cycle

    assign send_ok = send_valid && (credits != '0);
    assign stall   = send_valid && (credits == '0);   // freezes the pipe

    //////////////////////////////
    // credit count
    always_ff @(posedge clk) begin
        if (rst) begin
            credits   <= credit_cnt_t'(OUT_CREDITS);
            out_valid <= 1'b0;
        end else begin
            case ({send_ok, out_credit})
                2'b10:   credits <= credits - 1'b1;
                2'b01:   credits <= credits + 1'b1;
                default: credits <= credits;        // send and return cancel
            endcase
            out_valid <= send_ok;                   // one cycle pulse
        end
    end

    // descriptor lands one cycle after acceptance
    always_ff @(posedge clk) begin
        if (send_ok) out_desc <= send_desc;
    end

endmodule

`default_nettype wire

/* logic/p4_router_top.sv */
//////////////////////////////
// router top: buffer, port map, table, egress, drops
//////////////////////////////

`timescale 1ns/1ns
`default_nettype none

module p4_router_top (
    input  var logic                   clk,
    input  var logic                   rst,
    input  var logic                   in_valid,
    input  var router_pkg::pkt_desc_t  in_desc,
    output var logic                   in_credit,
    input  var logic                   tbl_wr_en,
    input  var router_pkg::tbl_idx_t   tbl_wr_idx,
    input  var router_pkg::tbl_entry_t tbl_wr_entry,
    output var logic                   out_valid,
    output var router_pkg::pkt_desc_t  out_desc,
    input  var logic                   out_credit,
    output var router_pkg::drop_cnt_t  drop_count
);

    import router_pkg::*;

    logic        head_valid;
    pkt_desc_t   head_desc;
    logic        pop;
    p4_port_t    ing_p4;
    logic        ing_bad;
    logic        req_valid;
    route_meta_t req_meta;
    logic        lkp_valid;
    logic        lkp_hit;
    route_meta_t lkp_meta;
    rtl_port_t   egr_rtl;
    logic        egr_bad;
    logic        send_valid;
    pkt_desc_t   send_desc;
    logic        stall;
    logic        ing_drop;
    logic        tbl_drop;

    ingress_buffer u_ingress_buffer (
        .clk, .rst, .in_valid, .in_desc, .pop,
        .head_valid, .head_desc, .in_credit
    );

    port_id_map u_port_id_map (
        .ing_rtl (head_desc.port), .ing_p4, .ing_bad,
        .egr_p4  (lkp_meta.egr_p4), .egr_rtl, .egr_bad
    );

    //////////////////////////////
    // pop and ingress drop
    assign pop       = head_valid && !stall;    // table stage advances
    assign ing_drop  = pop && ing_bad;          // unknown ingress idx
    assign req_valid = pop && !ing_bad;
    assign req_meta  = '{ing_p4: ing_p4, egr_p4: INVALID_PORT,
                         dst_addr: head_desc.dst_addr, tag: head_desc.tag};

    forward_table u_forward_table (
        .clk, .rst, .tbl_wr_en, .tbl_wr_idx, .tbl_wr_entry,
        .req_valid, .req_meta, .stall, .lkp_valid, .lkp_hit, .lkp_meta
    );

    // miss or unmapped egress id frees the stage
    assign tbl_drop   = lkp_valid && (!lkp_hit || egr_bad);
    assign send_valid = lkp_valid && lkp_hit && !egr_bad;
    assign send_desc  = '{port: egr_rtl, dst_addr: lkp_meta.dst_addr, tag: lkp_meta.tag};

    egress_credit u_egress_credit (
        .clk, .rst, .send_valid, .send_desc, .out_credit,
        .stall, .out_valid, .out_desc
    );

    //////////////////////////////
    // drop counter, two drops can land together
    always_ff @(posedge clk) begin
        if (rst) begin
            drop_count <= '0;
        end else begin
            drop_count <= drop_count + drop_cnt_t'(ing_drop) + drop_cnt_t'(tbl_drop);
        end
    end

endmodule

`default_nettype wire

/* verif/router_tb.sv */
//////////////////////////////
// file driven router testbench with credit sink and output checks
//////////////////////////////

`timescale 1ns/1ns
`default_nettype none

module router_tb;

    import router_pkg::*;

    localparam int MAX_RECS = 64;

    logic        clk;
    logic        rst;
    logic        in_valid;
    pkt_desc_t   in_desc;
    logic        in_credit;
    logic        tbl_wr_en;
    tbl_idx_t    tbl_wr_idx;
    tbl_entry_t  tbl_wr_entry;
    logic        out_valid;
    pkt_desc_t   out_desc;
    logic        out_credit;
    drop_cnt_t   drop_count;

    logic [47:0] recs [MAX_RECS];   // kind, a, dst_addr, b, c
    int          n_recs;
    int          n_drops;           // ff expectations in the file
    int          cycles;
    int          cycle_limit;       // 0 until the file is read
    int          mismatches;
    int          failures;
    int          in_cred;           // upstream credits held
    int          outstanding;       // egress credits sitting in the sink
    int          hold_cycles;       // sink keeps its credits while > 0
    logic [31:0] rnd_state;
    pkt_desc_t   exp_q [$];         // expected egress, in order
    int          due_q [$];         // cycle each credit goes back

    p4_router_top u_p4_router_top (
        .clk, .rst, .in_valid, .in_desc, .in_credit,
        .tbl_wr_en, .tbl_wr_idx, .tbl_wr_entry,
        .out_valid, .out_desc, .out_credit, .drop_count
    );

    initial clk = 1'b0;
    always #50 clk = ~clk;          // 100 ns period

    function automatic logic [31:0] lcg_step(input logic [31:0] s);
        return s * 32'd1103515245 + 32'd12345;
    endfunction

    task automatic note_failure(input string msg);
        failures++;
        $display("%s", msg);
    endtask

    task automatic check_desc(input pkt_desc_t got, input pkt_desc_t exp);
        if (got !== exp) begin
            mismatches++;
            $display("MISMATCH out_desc got %h expected %h", got, exp);
        end
    endtask

    task automatic check_count(input drop_cnt_t got, input drop_cnt_t exp);
        if (got !== exp) begin
            mismatches++;
            $display("MISMATCH drop_count got %h expected %h", got, exp);
        end
    endtask

    //////////////////////////////
    // cycle counter and timeout
    always @(posedge clk) begin
        cycles++;
        if (cycle_limit > 0 && cycles > cycle_limit) begin
            failures++;
            $display("timeout after %0d cycles, %0d packets never arrived", cycles, exp_q.size());
            $display("errors: %0d mismatches, %0d other failures", mismatches, failures);
            $display("Checks failed");
            $finish;
        end
    end

    //////////////////////////////
    // sink returns one credit per cycle once due
    always begin
        @(posedge clk);
        #1;
        if (hold_cycles > 0) begin
            hold_cycles--;              // router runs dry of credits
            out_credit = 1'b0;
        end else if (due_q.size() > 0 && due_q[0] <= cycles) begin
            void'(due_q.pop_front());
            outstanding--;
            out_credit = 1'b1;
        end else begin
            out_credit = 1'b0;
        end
    end

    //////////////////////////////
    // output and credit monitor at mid cycle
    always @(negedge clk) begin
        if (!rst) begin
            if (in_credit) begin
                in_cred++;
                if (in_cred > IN_CREDITS) begin
                    note_failure("ingress credit returned beyond the buffer depth");
                end
            end
            if (out_valid) begin
                outstanding++;
                if (outstanding > OUT_CREDITS) begin
                    note_failure("out_valid while the router held no egress credit");
                end
                rnd_state = lcg_step(rnd_state);
                due_q.push_back(cycles + 1 + int'(rnd_state[17:16]));  // 0 to 3 extra
                if (exp_q.size() == 0) begin
                    note_failure("unexpected output with no packet pending");
                end else begin
                    check_desc(out_desc, exp_q.pop_front());
                end
            end
        end
    end

    // lookups of earlier packets finish before the table changes
    task automatic write_entry(input logic [47:0] r);
        while (in_cred != IN_CREDITS) begin
            @(posedge clk);
            #1;
        end
        tbl_wr_en    = 1'b1;
        tbl_wr_idx   = r[34:32];
        tbl_wr_entry = '{valid: r[0], dst_addr: r[31:16], egr_p4: r[15:8]};
        @(posedge clk);
        #1;
        tbl_wr_en = 1'b0;
    endtask

    task automatic send_packet(input logic [47:0] r);
        pkt_desc_t exp_d;
        while (in_cred == 0) begin      // wait for a credit back
            @(posedge clk);
            #1;
        end
        in_valid = 1'b1;
        in_desc  = '{port: r[39:32], dst_addr: r[31:16], tag: r[15:8]};
        in_cred--;
        if (r[7:0] != 8'hFF) begin
            exp_d = '{port: r[7:0], dst_addr: r[31:16], tag: r[15:8]};
            exp_q.push_back(exp_d);
        end
        @(posedge clk);
        #1;
        in_valid = 1'b0;
    endtask

    //////////////////////////////
    // main sequence
    initial begin
        logic [47:0] r;
        rst          = 1'b1;
        in_valid     = 1'b0;
        in_desc      = '0;
        tbl_wr_en    = 1'b0;
        tbl_wr_idx   = '0;
        tbl_wr_entry = '0;
        out_credit   = 1'b0;
        cycles       = 0;
        cycle_limit  = 0;
        mismatches   = 0;
        failures     = 0;
        in_cred      = IN_CREDITS;
        outstanding  = 0;
        hold_cycles  = 0;
        n_recs       = 0;
        n_drops      = 0;
        rnd_state    = 32'h557b;
        for (int i = 0; i < MAX_RECS; i++) begin
            recs[i] = {8'hFF, 40'(i)};  // end marker past the file
        end
        $readmemh("verif/router_tests.txt", recs);
        while (n_recs < MAX_RECS && recs[n_recs][47:40] != 8'hFF) begin
            if (recs[n_recs][47:40] == 8'h01 && recs[n_recs][7:0] == 8'hFF) begin
                n_drops++;
            end
            n_recs++;
        end
        cycle_limit = 40 * n_recs + 200;

        repeat (2) @(posedge clk);
        #1;
        rst = 1'b0;

        for (int i = 0; i < n_recs; i++) begin
            r = recs[i];
            case (r[47:40])
                8'h00:   write_entry(r);
                8'h01:   send_packet(r);
                8'h02:   hold_cycles = int'(r[7:0]);
                default: note_failure("unknown record kind in the test file");
            endcase
        end

        // drain until all packets are out and all credits are home
        while (exp_q.size() != 0 || in_cred != IN_CREDITS || outstanding != 0) begin
            @(posedge clk);
            #1;
        end
        repeat (2) @(posedge clk);      // last drop lands a cycle after lookup
        #1;
        check_count(drop_count, drop_cnt_t'(n_drops));

        $display("errors: %0d mismatches, %0d other failures", mismatches, failures);
        if (mismatches == 0 && failures == 0) begin
            $display("All checks passed");
        end else begin
            $display("Checks failed");
        end
        $finish;
    end

endmodule

`default_nettype wire

/* verif/router_tests.txt */
// kind_a_dstaddr_b_c  kind 00 write: a idx, b egr_p4, c valid | kind 02 sink hold: c cycles
// kind 01 packet: a ingress idx, b tag, c expected egress idx (ff = drop) | kind ff ends
00_00_1000_00_01
00_01_1001_14_01
00_02_1002_29_01
00_03_1003_3D_01
00_04_1004_52_01
00_05_1000_53_01
00_06_1006_16_01
00_07_1007_50_00
01_00_1001_01_01
01_01_1002_02_04
01_02_1003_03_06
01_03_1004_04_09
01_04_1000_05_00
01_05_1001_06_01
01_06_1002_07_04
01_07_1003_08_06
01_08_1004_09_09
01_09_1000_0A_00
01_0A_1001_0B_01
01_0B_1001_0C_FF
01_20_1001_0D_FF
01_03_2000_0E_FF
01_03_1007_0F_FF
01_03_1006_10_FF
02_00_0000_00_14
01_01_1004_11_09
01_02_1004_12_09
01_03_1004_13_09
01_04_1004_14_09
01_05_1004_15_09
01_06_1004_16_09
00_00_1000_3C_01
01_02_1000_17_05
FF_00_0000_00_00

/* build.f */
logic/router_pkg.sv
logic/port_id_map.sv
logic/ingress_buffer.sv
logic/forward_table.sv
logic/egress_credit.sv
logic/p4_router_top.sv
verif/router_tb.sv

/* Makefile */
VERILATOR ?= verilator
TOP       ?= router_tb
FILELIST  ?= build.f
OBJ_DIR   ?= obj_dir
VFLAGS    ?= --binary --timing -Wno-fatal
PASS_MSG  ?= All checks passed

SRCS := $(shell cat $(FILELIST))
BIN  := $(OBJ_DIR)/V$(TOP)

.PHONY: all run build lint clean

all: run

build: $(BIN)

$(BIN): $(FILELIST) $(SRCS)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)

run: build
	@out="$$(./$(BIN))"; echo "$$out"; echo "$$out" | grep -q "$(PASS_MSG)"

lint:
	$(VERILATOR) --lint-only --timing --top-module $(TOP) -f $(FILELIST)

clean:
	rm -rf $(OBJ_DIR)
